// File: Makefile
# Verilator flow for the compute-unit read-side control
TOP = cu_control_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
source/cu_control_pkg.sv
source/cmd_queue.sv
source/read_cmd_arbiter.sv
source/read_response_router.sv
source/job_progress.sv
source/cu_control.sv
dv/cu_control_tb.sv

// File: dv/cu_control_tb.sv
/*
 * Testbench for the compute-unit read-side control.
 * Reads command records and job totals from the testdata file,
 * pushes them through both command queues, checks the merged read
 * command stream, routed responses and job completion. Run from the
 * project root so the data file path resolves.
 */

`timescale 1ns/1ps
`default_nettype none

module cu_control_tb;
	import cu_control_pkg::*;

	localparam int QUEUE_DEPTH = 8;
	localparam int MAX_RECORDS = 64;

	logic                   clock;
	logic                   rstn;
	logic                   enable;
	logic                   read_buffer_alfull;
	logic                   vertex_cmd_valid;
	logic [ADDR_WIDTH-1:0]  vertex_cmd_addr;
	logic [TAG_WIDTH-1:0]   vertex_cmd_tag;
	logic                   vertex_cmd_ready;
	logic                   algorithm_cmd_valid;
	logic [ADDR_WIDTH-1:0]  algorithm_cmd_addr;
	logic [TAG_WIDTH-1:0]   algorithm_cmd_tag;
	logic                   algorithm_cmd_ready;
	logic                   read_cmd_valid;
	cu_id_t                 read_cmd_cu_id;
	logic [ADDR_WIDTH-1:0]  read_cmd_addr;
	logic [TAG_WIDTH-1:0]   read_cmd_tag;
	logic                   read_cmd_ready;
	logic                   read_rsp_valid;
	cu_id_t                 read_rsp_cu_id;
	logic [TAG_WIDTH-1:0]   read_rsp_tag;
	logic                   vertex_rsp_valid;
	logic [TAG_WIDTH-1:0]   vertex_rsp_tag;
	logic                   algorithm_rsp_valid;
	logic [TAG_WIDTH-1:0]   algorithm_rsp_tag;
	logic                   job_valid;
	logic [COUNT_WIDTH-1:0] job_num_vertices;
	logic [COUNT_WIDTH-1:0] job_num_edges;
	logic                   job_done;
	logic [COUNT_WIDTH-1:0] vertices_done;
	logic [COUNT_WIDTH-1:0] edges_done;

	// record = {test, source, tag, address}
	logic [47:0] records [MAX_RECORDS];
	logic [47:0] exp_vertex [$];
	logic [47:0] exp_algorithm [$];
	int          picked [$];
	int          num_records;
	int          cycle_count;
	int          cycle_limit;
	int          error_count;
	int          errors_at_start;
	int          tests_run;
	int          tests_failed;
	logic [31:0] lcg_state;

	cu_control #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("run stopped after %0d cycles with tests still running", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	task automatic select_records(input int test);
		int i;
		picked.delete();
		for (i = 0; i < num_records; i++) begin
			if (records[i][47:44] == test[3:0])
				picked.push_back(i);
		end
	endtask

	task automatic apply_reset();
		rstn = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		rstn = 1'b1;
		check_value("read_cmd_valid", read_cmd_valid, 1'b0);
		check_value("vertex_rsp_valid", vertex_rsp_valid, 1'b0);
		check_value("algorithm_rsp_valid", algorithm_rsp_valid, 1'b0);
		check_value("job_done", job_done, 1'b0);
		check_value("vertex_cmd_ready", vertex_cmd_ready, 1'b1);
		check_value("algorithm_cmd_ready", algorithm_cmd_ready, 1'b1);
	endtask

	task automatic drive_cmd(input logic [47:0] rec);
		if (rec[43:40] == 4'h0) begin
			vertex_cmd_valid = 1'b1;
			vertex_cmd_addr  = rec[31:0];
			vertex_cmd_tag   = rec[39:32];
		end else begin
			algorithm_cmd_valid = 1'b1;
			algorithm_cmd_addr  = rec[31:0];
			algorithm_cmd_tag   = rec[39:32];
		end
	endtask

	// holds valid until the queue takes the command
	task automatic push_cmd(input logic [47:0] rec);
		logic is_vertex;
		is_vertex = (rec[43:40] == 4'h0);
		drive_cmd(rec);
		while (is_vertex ? !vertex_cmd_ready : !algorithm_cmd_ready)
			step();
		if (is_vertex)
			exp_vertex.push_back(rec);
		else
			exp_algorithm.push_back(rec);
		step();
		if (is_vertex)
			vertex_cmd_valid = 1'b0;
		else
			algorithm_cmd_valid = 1'b0;
	endtask

	// takes read commands until total arrived, matching each to its source queue
	task automatic drain_cmds(input int total, input bit alternate, input bit random_stall);
		int          received;
		logic [47:0] rec;
		logic [31:0] rnd;
		bit          found;
		received = 0;
		while (received < total) begin
			if (random_stall) begin
				rnd = next_random();
				read_cmd_ready     = rnd[20];
				read_buffer_alfull = rnd[25] & rnd[27];
			end else begin
				read_cmd_ready     = 1'b1;
				read_buffer_alfull = 1'b0;
			end
			if (read_cmd_valid && read_cmd_ready) begin
				if (alternate)
					check_value("read_cmd_cu_id", read_cmd_cu_id, received[0]);
				found = 1'b0;
				if (read_cmd_cu_id == CU_VERTEX && exp_vertex.size() > 0) begin
					rec   = exp_vertex.pop_front();
					found = 1'b1;
				end else if (read_cmd_cu_id == CU_ALGORITHM && exp_algorithm.size() > 0) begin
					rec   = exp_algorithm.pop_front();
					found = 1'b1;
				end
				if (!found) begin
					$display("read command at %0t ns has no matching queued command", $time);
					error_count++;
				end else begin
					check_value("read_cmd_addr", read_cmd_addr, rec[31:0]);
					check_value("read_cmd_tag", read_cmd_tag, rec[39:32]);
				end
				received++;
			end
			step();
		end
		read_cmd_ready     = 1'b1;
		read_buffer_alfull = 1'b0;
	endtask

	task automatic expect_idle();
		int i;
		if (exp_vertex.size() != 0 || exp_algorithm.size() != 0) begin
			$display("queued commands never reached the read command output");
			error_count++;
		end
		for (i = 0; i < 4; i++) begin
			step();
			check_value("read_cmd_valid", read_cmd_valid, 1'b0);
		end
	endtask

	task automatic drive_response(input logic [47:0] rec);
		read_rsp_valid = 1'b1;
		read_rsp_cu_id = cu_id_t'(rec[40]);
		read_rsp_tag   = rec[39:32];
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic test_queue_capacity();
		int i;
		select_records(1);
		if (picked.size() != QUEUE_DEPTH + 1) begin
			$display("testdata holds %0d capacity records, needs %0d", picked.size(),
				QUEUE_DEPTH + 1);
			error_count++;
			return;
		end
		enable = 1'b0;
		for (i = 0; i < QUEUE_DEPTH; i++) begin
			check_value("vertex_cmd_ready", vertex_cmd_ready, 1'b1);
			push_cmd(records[picked[i]]);
		end
		// full queue stalls the extra push
		drive_cmd(records[picked[QUEUE_DEPTH]]);
		check_value("vertex_cmd_ready", vertex_cmd_ready, 1'b0);
		step();
		check_value("vertex_cmd_ready", vertex_cmd_ready, 1'b0);
		enable = 1'b1;
		fork
			push_cmd(records[picked[QUEUE_DEPTH]]);
			drain_cmds(QUEUE_DEPTH + 1, 1'b0, 1'b0);
		join
		expect_idle();
	endtask

	task automatic test_round_robin();
		int i;
		apply_reset();
		select_records(2);
		enable = 1'b0;
		for (i = 0; i < picked.size(); i++)
			push_cmd(records[picked[i]]);
		enable = 1'b1;
		drain_cmds(picked.size(), 1'b1, 1'b0);
		expect_idle();
	endtask

	task automatic test_back_pressure();
		int i;
		select_records(3);
		fork
			begin
				for (i = 0; i < picked.size(); i++)
					push_cmd(records[picked[i]]);
			end
			drain_cmds(picked.size(), 1'b0, 1'b1);
		join
		expect_idle();
	endtask

	task automatic test_response_routing();
		int          i;
		logic [47:0] rec;
		select_records(3);
		for (i = 0; i < picked.size(); i++) begin
			rec = records[picked[i]];
			drive_response(rec);
			step();
			check_value("vertex_rsp_valid", vertex_rsp_valid, rec[43:40] == 4'h0);
			check_value("algorithm_rsp_valid", algorithm_rsp_valid, rec[43:40] == 4'h1);
			if (rec[43:40] == 4'h0)
				check_value("vertex_rsp_tag", vertex_rsp_tag, rec[39:32]);
			else
				check_value("algorithm_rsp_tag", algorithm_rsp_tag, rec[39:32]);
		end
		read_rsp_valid = 1'b0;
		step();
		check_value("vertex_rsp_valid", vertex_rsp_valid, 1'b0);
		check_value("algorithm_rsp_valid", algorithm_rsp_valid, 1'b0);
	endtask

	task automatic test_job_completion();
		int          i;
		logic [47:0] job;
		select_records(5);
		job              = records[picked[0]];
		job_valid        = 1'b1;
		job_num_vertices = job[31:16];
		job_num_edges    = job[15:0];
		step();
		job_valid = 1'b0;
		// responses for the round-robin commands
		select_records(2);
		for (i = 0; i < picked.size(); i++) begin
			drive_response(records[picked[i]]);
			step();
			check_value("job_done", job_done, 1'b0);
		end
		read_rsp_valid = 1'b0;
		step();
		check_value("job_done", job_done, 1'b1);
		check_value("vertices_done", vertices_done, job[31:16]);
		check_value("edges_done", edges_done, job[15:0]);
		job_valid = 1'b1;
		step();
		job_valid = 1'b0;
		check_value("job_done", job_done, 1'b0);
		check_value("vertices_done", vertices_done, '0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rstn                = 1'b0;
		enable              = 1'b0;
		read_buffer_alfull  = 1'b0;
		vertex_cmd_valid    = 1'b0;
		vertex_cmd_addr     = '0;
		vertex_cmd_tag      = '0;
		algorithm_cmd_valid = 1'b0;
		algorithm_cmd_addr  = '0;
		algorithm_cmd_tag   = '0;
		read_cmd_ready      = 1'b1;
		read_rsp_valid      = 1'b0;
		read_rsp_cu_id      = CU_VERTEX;
		read_rsp_tag        = '0;
		job_valid           = 1'b0;
		job_num_vertices    = '0;
		job_num_edges       = '0;
		error_count         = 0;
		errors_at_start     = 0;
		tests_run           = 0;
		tests_failed        = 0;
		cycle_count         = 0;
		lcg_state           = 32'h2a49d02b;
		for (int i = 0; i < MAX_RECORDS; i++)
			records[i] = '0;
		$readmemh("dv/cu_control_testdata.txt", records);
		num_records = 0;
		while (num_records < MAX_RECORDS && records[num_records][47:44] != 4'h0)
			num_records++;
		cycle_limit = 40 * num_records;

		apply_reset();
		test_queue_capacity();
		finish_test("queue capacity");
		test_round_robin();
		finish_test("round-robin order");
		test_back_pressure();
		finish_test("back-pressure and almost-full");
		test_response_routing();
		finish_test("response routing");
		test_job_completion();
		finish_test("job completion");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/cu_control_testdata.txt
// one record per line, 12 hex digits: test(1) source(1) tag(2) address(8)
// source 0 vertex, 1 algorithm, 2 job totals with address = vertices(4) edges(4)
101000001000
102000001040
103000001080
1040000010c0
105000001100
106000001140
107000001180
1080000011c0
109000001200
202100002000
202200002100
202300002200
202400002300
2131a0008000
2132a0008100
2133a0008200
2134a0008300
3041c0000000
3151d0000040
3042c0000080
3043c00000c0
3152d0000100
3153d0000140
520000040004

// File: source/cmd_queue.sv
/*
 * Synchronous command FIFO for one job source.
 * Accepts address/tag pairs through valid/ready and presents the
 * oldest entry at the head for the arbiter. A pushed entry shows
 * at the head one cycle later. Ready drops only when the queue
 * holds QUEUE_DEPTH entries; QUEUE_DEPTH must be a power of two.
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  in_valid,
	input  logic [cu_control_pkg::ADDR_WIDTH-1:0] in_addr,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0]  in_tag,
	output logic                                  in_ready,
	output logic                                  head_valid,
	output logic [cu_control_pkg::ADDR_WIDTH-1:0] head_addr,
	output logic [cu_control_pkg::TAG_WIDTH-1:0]  head_tag,
	input  logic                                  head_ready
);
	import cu_control_pkg::*;

	localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

	logic [ADDR_WIDTH-1:0] addr_mem [QUEUE_DEPTH];
	logic [TAG_WIDTH-1:0]  tag_mem  [QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0]  wr_ptr;
	logic [PTR_WIDTH-1:0]  rd_ptr;
	logic [PTR_WIDTH:0]    count;
	logic                  push;
	logic                  pop;

	assign in_ready   = (count != QUEUE_DEPTH[PTR_WIDTH:0]);
	assign head_valid = (count != '0);
	assign push       = in_valid && in_ready;
	assign pop        = head_valid && head_ready;

	// head read straight from storage
	assign head_addr = addr_mem[rd_ptr];
	assign head_tag  = tag_mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// pointers wrap on their own since depth is a power of two
			count <= count + {{PTR_WIDTH{1'b0}}, push} - {{PTR_WIDTH{1'b0}}, pop};
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			addr_mem[wr_ptr] <= in_addr;
			tag_mem[wr_ptr]  <= in_tag;
		end
	end

	// an underflow would wrap the count above the depth as well
	assert property (@(posedge clock) disable iff (!rstn) count <= QUEUE_DEPTH);

endmodule

`default_nettype wire

// File: source/cu_control.sv
/*
 * Read-side control of one compute unit.
 * Two command queues buffer the vertex and algorithm read
 * commands, a round-robin arbiter merges them into one read
 * command stream, the router returns responses to their source,
 * and the tracker reports job completion.
 */

`timescale 1ns/1ps
`default_nettype none

module cu_control #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   enable,
	input  logic                                   read_buffer_alfull,
	input  logic                                   vertex_cmd_valid,
	input  logic [cu_control_pkg::ADDR_WIDTH-1:0]  vertex_cmd_addr,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0]   vertex_cmd_tag,
	output logic                                   vertex_cmd_ready,
	input  logic                                   algorithm_cmd_valid,
	input  logic [cu_control_pkg::ADDR_WIDTH-1:0]  algorithm_cmd_addr,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0]   algorithm_cmd_tag,
	output logic                                   algorithm_cmd_ready,
	output logic                                   read_cmd_valid,
	output cu_control_pkg::cu_id_t                 read_cmd_cu_id,
	output logic [cu_control_pkg::ADDR_WIDTH-1:0]  read_cmd_addr,
	output logic [cu_control_pkg::TAG_WIDTH-1:0]   read_cmd_tag,
	input  logic                                   read_cmd_ready,
	input  logic                                   read_rsp_valid,
	input  cu_control_pkg::cu_id_t                 read_rsp_cu_id,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0]   read_rsp_tag,
	output logic                                   vertex_rsp_valid,
	output logic [cu_control_pkg::TAG_WIDTH-1:0]   vertex_rsp_tag,
	output logic                                   algorithm_rsp_valid,
	output logic [cu_control_pkg::TAG_WIDTH-1:0]   algorithm_rsp_tag,
	input  logic                                   job_valid,
	input  logic [cu_control_pkg::COUNT_WIDTH-1:0] job_num_vertices,
	input  logic [cu_control_pkg::COUNT_WIDTH-1:0] job_num_edges,
	output logic                                   job_done,
	output logic [cu_control_pkg::COUNT_WIDTH-1:0] vertices_done,
	output logic [cu_control_pkg::COUNT_WIDTH-1:0] edges_done
);
	import cu_control_pkg::*;

	// queue heads toward the arbiter
	logic                  vertex_head_valid;
	logic [ADDR_WIDTH-1:0] vertex_head_addr;
	logic [TAG_WIDTH-1:0]  vertex_head_tag;
	logic                  vertex_head_ready;
	logic                  algorithm_head_valid;
	logic [ADDR_WIDTH-1:0] algorithm_head_addr;
	logic [TAG_WIDTH-1:0]  algorithm_head_tag;
	logic                  algorithm_head_ready;

	////////////////////////////////////////////////////////////
	// command queues
	////////////////////////////////////////////////////////////

	cmd_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_vertex_queue (
		.clock      (clock),
		.rstn       (rstn),
		.in_valid   (vertex_cmd_valid),
		.in_addr    (vertex_cmd_addr),
		.in_tag     (vertex_cmd_tag),
		.in_ready   (vertex_cmd_ready),
		.head_valid (vertex_head_valid),
		.head_addr  (vertex_head_addr),
		.head_tag   (vertex_head_tag),
		.head_ready (vertex_head_ready)
	);

	cmd_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_algorithm_queue (
		.clock      (clock),
		.rstn       (rstn),
		.in_valid   (algorithm_cmd_valid),
		.in_addr    (algorithm_cmd_addr),
		.in_tag     (algorithm_cmd_tag),
		.in_ready   (algorithm_cmd_ready),
		.head_valid (algorithm_head_valid),
		.head_addr  (algorithm_head_addr),
		.head_tag   (algorithm_head_tag),
		.head_ready (algorithm_head_ready)
	);

	////////////////////////////////////////////////////////////
	// arbitration, routing, progress
	////////////////////////////////////////////////////////////

	read_cmd_arbiter u_arbiter (
		.clock                (clock),
		.rstn                 (rstn),
		.enable               (enable),
		.read_buffer_alfull   (read_buffer_alfull),
		.read_cmd_ready       (read_cmd_ready),
		.vertex_head_valid    (vertex_head_valid),
		.vertex_head_addr     (vertex_head_addr),
		.vertex_head_tag      (vertex_head_tag),
		.algorithm_head_valid (algorithm_head_valid),
		.algorithm_head_addr  (algorithm_head_addr),
		.algorithm_head_tag   (algorithm_head_tag),
		.vertex_head_ready    (vertex_head_ready),
		.algorithm_head_ready (algorithm_head_ready),
		.read_cmd_valid       (read_cmd_valid),
		.read_cmd_cu_id       (read_cmd_cu_id),
		.read_cmd_addr        (read_cmd_addr),
		.read_cmd_tag         (read_cmd_tag)
	);

	read_response_router u_router (
		.clock               (clock),
		.rstn                (rstn),
		.rsp_valid           (read_rsp_valid),
		.rsp_cu_id           (read_rsp_cu_id),
		.rsp_tag             (read_rsp_tag),
		.vertex_rsp_valid    (vertex_rsp_valid),
		.vertex_rsp_tag      (vertex_rsp_tag),
		.algorithm_rsp_valid (algorithm_rsp_valid),
		.algorithm_rsp_tag   (algorithm_rsp_tag)
	);

	job_progress u_progress (
		.clock               (clock),
		.rstn                (rstn),
		.job_valid           (job_valid),
		.job_num_vertices    (job_num_vertices),
		.job_num_edges       (job_num_edges),
		.vertex_rsp_valid    (vertex_rsp_valid),
		.algorithm_rsp_valid (algorithm_rsp_valid),
		.job_done            (job_done),
		.vertices_done       (vertices_done),
		.edges_done          (edges_done)
	);

endmodule

`default_nettype wire

// File: source/cu_control_pkg.sv
/*
 * Shared definitions for the compute-unit read-side control.
 * Holds the compute-unit id that tags every read command and
 * response, and the field widths of addresses, tags and job
 * counters. Modules import it inside their bodies and use
 * scoped names in their port lists.
 */

`default_nettype none

package cu_control_pkg;

	////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////

	// read command address
	parameter int ADDR_WIDTH = 32;

	// command and response tag
	parameter int TAG_WIDTH = 8;

	// job totals and completion counters
	parameter int COUNT_WIDTH = 16;

	////////////////////////////////////////////////////////////
	// compute-unit ids
	////////////////////////////////////////////////////////////

	// one id per job source, carried on commands and responses
	typedef enum logic {
		CU_VERTEX    = 1'b0,
		CU_ALGORITHM = 1'b1
	} cu_id_t;

endpackage

`default_nettype wire

// File: source/job_progress.sv
/*
 * Job progress tracker for one compute unit.
 * A one-cycle job_valid loads the vertex and edge totals of the
 * job descriptor and clears both counters. Routed vertex and edge
 * responses are counted, and job_done rises together with the
 * counter update that reaches both totals. It holds until the
 * next job_valid.
 */

`timescale 1ns/1ps
`default_nettype none

module job_progress (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   job_valid,
	input  logic [cu_control_pkg::COUNT_WIDTH-1:0] job_num_vertices,
	input  logic [cu_control_pkg::COUNT_WIDTH-1:0] job_num_edges,
	input  logic                                   vertex_rsp_valid,
	input  logic                                   algorithm_rsp_valid,
	output logic                                   job_done,
	output logic [cu_control_pkg::COUNT_WIDTH-1:0] vertices_done,
	output logic [cu_control_pkg::COUNT_WIDTH-1:0] edges_done
);
	import cu_control_pkg::*;

	logic [COUNT_WIDTH-1:0] total_vertices;
	logic [COUNT_WIDTH-1:0] total_edges;
	logic [COUNT_WIDTH-1:0] vertices_next;
	logic [COUNT_WIDTH-1:0] edges_next;
	logic                   job_loaded;

	// counts after this edge
	assign vertices_next = vertices_done + {{(COUNT_WIDTH-1){1'b0}}, vertex_rsp_valid};
	assign edges_next    = edges_done + {{(COUNT_WIDTH-1){1'b0}}, algorithm_rsp_valid};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_loaded    <= 1'b0;
			job_done      <= 1'b0;
			vertices_done <= '0;
			edges_done    <= '0;
		end else if (job_valid) begin
			job_loaded    <= 1'b1;
			job_done      <= 1'b0;
			vertices_done <= '0;
			edges_done    <= '0;
		end else begin
			vertices_done <= vertices_next;
			edges_done    <= edges_next;
			// sticky once both totals are met
			job_done <= job_done || (job_loaded && (vertices_next == total_vertices)
				&& (edges_next == total_edges));
		end
	end

	always_ff @(posedge clock) begin
		if (job_valid) begin
			total_vertices <= job_num_vertices;
			total_edges    <= job_num_edges;
		end
	end

endmodule

`default_nettype wire

// File: source/read_cmd_arbiter.sv
/*
 * Round-robin merge of the vertex and algorithm command queues.
 * Loads one head per cycle into a one-entry output register and
 * stamps it with the compute-unit id of its source. Nothing is
 * loaded while disabled, while the downstream buffer is almost
 * full, or while the output register is stalled.
 */

`timescale 1ns/1ps
`default_nettype none

module read_cmd_arbiter (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  enable,
	input  logic                                  read_buffer_alfull,
	input  logic                                  read_cmd_ready,
	input  logic                                  vertex_head_valid,
	input  logic [cu_control_pkg::ADDR_WIDTH-1:0] vertex_head_addr,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0]  vertex_head_tag,
	input  logic                                  algorithm_head_valid,
	input  logic [cu_control_pkg::ADDR_WIDTH-1:0] algorithm_head_addr,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0]  algorithm_head_tag,
	output logic                                  vertex_head_ready,
	output logic                                  algorithm_head_ready,
	output logic                                  read_cmd_valid,
	output cu_control_pkg::cu_id_t                read_cmd_cu_id,
	output logic [cu_control_pkg::ADDR_WIDTH-1:0] read_cmd_addr,
	output logic [cu_control_pkg::TAG_WIDTH-1:0]  read_cmd_tag
);
	import cu_control_pkg::*;

	cu_id_t pref;
	logic   load_en;
	logic   pick_vertex;
	logic   pick_algorithm;

	// output register empty or draining this cycle
	assign load_en = enable && !read_buffer_alfull && (!read_cmd_valid || read_cmd_ready);

	////////////////////////////////////////////////////////////
	// round-robin pick
	////////////////////////////////////////////////////////////

	always_comb begin
		if (pref == CU_VERTEX) begin
			pick_vertex    = vertex_head_valid;
			pick_algorithm = !vertex_head_valid && algorithm_head_valid;
		end else begin
			pick_algorithm = algorithm_head_valid;
			pick_vertex    = !algorithm_head_valid && vertex_head_valid;
		end
	end

	assign vertex_head_ready    = load_en && pick_vertex;
	assign algorithm_head_ready = load_en && pick_algorithm;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid <= 1'b0;
			pref           <= CU_VERTEX;
		end else begin
			if (load_en) begin
				read_cmd_valid <= pick_vertex || pick_algorithm;
				// hand preference to the source not served
				if (pick_vertex)
					pref <= CU_ALGORITHM;
				else if (pick_algorithm)
					pref <= CU_VERTEX;
			end else if (read_cmd_ready) begin
				read_cmd_valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output command register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (vertex_head_ready) begin
			read_cmd_cu_id <= CU_VERTEX;
			read_cmd_addr  <= vertex_head_addr;
			read_cmd_tag   <= vertex_head_tag;
		end else if (algorithm_head_ready) begin
			read_cmd_cu_id <= CU_ALGORITHM;
			read_cmd_addr  <= algorithm_head_addr;
			read_cmd_tag   <= algorithm_head_tag;
		end
	end

	// a stalled command holds until taken
	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid && !read_cmd_ready |=> read_cmd_valid && $stable(read_cmd_cu_id)
			&& $stable(read_cmd_addr) && $stable(read_cmd_tag));

	// at most one queue popped per cycle
	assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_head_ready && algorithm_head_ready));

endmodule

`default_nettype wire

// File: source/read_response_router.sv
/*
 * Steers read responses back to their job source.
 * Each response carries the compute-unit id of the command that
 * produced it. The router registers the response onto the
 * matching source port one cycle after it arrives; routed valids
 * are single-cycle pulses. Responses cannot be stalled.
 */

`timescale 1ns/1ps
`default_nettype none

module read_response_router (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 rsp_valid,
	input  cu_control_pkg::cu_id_t               rsp_cu_id,
	input  logic [cu_control_pkg::TAG_WIDTH-1:0] rsp_tag,
	output logic                                 vertex_rsp_valid,
	output logic [cu_control_pkg::TAG_WIDTH-1:0] vertex_rsp_tag,
	output logic                                 algorithm_rsp_valid,
	output logic [cu_control_pkg::TAG_WIDTH-1:0] algorithm_rsp_tag
);
	import cu_control_pkg::*;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_rsp_valid    <= 1'b0;
			algorithm_rsp_valid <= 1'b0;
		end else begin
			vertex_rsp_valid    <= rsp_valid && (rsp_cu_id == CU_VERTEX);
			algorithm_rsp_valid <= rsp_valid && (rsp_cu_id == CU_ALGORITHM);
		end
	end

	// tag only moves on the port being addressed
	always_ff @(posedge clock) begin
		if (rsp_valid) begin
			case (rsp_cu_id)
				CU_VERTEX: vertex_rsp_tag <= rsp_tag;
				CU_ALGORITHM: algorithm_rsp_tag <= rsp_tag;
			endcase
		end
	end

	// never both ports in one cycle
	assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_rsp_valid && algorithm_rsp_valid));

endmodule

`default_nettype wire
